/* verilog/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    localparam int BLOCK_OFFSET_BITS = 3;                   // 8-byte lines
    localparam int BLOCK_BITS = 8 << BLOCK_OFFSET_BITS;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [BLOCK_BITS-1:0] block_t;
    typedef logic [1:0] size_t;

    localparam size_t size_byte = 2'd0;
    localparam size_t size_half = 2'd1;
    localparam size_t size_word = 2'd2;

    typedef enum logic [1:0] {
        idle,
        refill,       // read outstanding on the memory channel
        writeback,    // dirty victim going out
        respond
    } ctrl_state_e;

    // overlay a naturally aligned store onto a line
    function automatic block_t store_merge(block_t line, addr_t addr, size_t size, word_t wdata);
        block_t mask;
        block_t data;
        int unsigned shift;
        case (size)
            size_byte: mask = block_t'(8'hff);
            size_half: mask = block_t'(16'hffff);
            default:   mask = block_t'(32'hffff_ffff);
        endcase
        shift = addr[BLOCK_OFFSET_BITS-1:0] * 8;            // byte offset in bits
        data = block_t'(wdata) & mask;
        return (line & ~(mask << shift)) | (data << shift);
    endfunction

endpackage

`default_nettype wire

/* verilog/main_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module main_cache
    import dcache_pkg::*;
#(
    parameter int N_LINES = 16
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   lookup,
    input  logic   write,
    input  logic   fill,
    input  addr_t  addr,
    input  size_t  size,
    input  word_t  wdata,
    input  block_t fill_block,
    output logic   main_hit,
    output block_t main_block,
    output logic   evict_valid,
    output logic   evict_dirty,
    output addr_t  evict_addr,
    output block_t evict_block
);

    localparam int INDEX_BITS = $clog2(N_LINES);
    localparam int TAG_BITS = 32 - INDEX_BITS - BLOCK_OFFSET_BITS;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0] tag_t;

    logic [N_LINES-1:0] line_valid;
    logic [N_LINES-1:0] line_dirty;
    tag_t               line_tag [N_LINES];
    block_t             line_data [N_LINES];

    index_t index;
    tag_t   tag;
    block_t fill_line;

    assign index = addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
    assign tag = addr[31 -: TAG_BITS];

    assign main_hit = lookup && line_valid[index] && (line_tag[index] == tag);
    assign main_block = line_data[index];

    // a store miss allocates with the store already applied
    assign fill_line = write ? store_merge(fill_block, addr, size, wdata) : fill_block;

    // old occupant of the indexed line leaves on the fill edge
    assign evict_valid = fill && line_valid[index];
    assign evict_dirty = line_dirty[index];
    assign evict_addr = {line_tag[index], index, {BLOCK_OFFSET_BITS{1'b0}}};
    assign evict_block = line_data[index];

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
            line_dirty <= '0;
        end else if (fill) begin
            line_valid[index] <= 1'b1;
            line_dirty[index] <= write;              // clean unless a store rode in
        end else if (main_hit && write) begin
            line_dirty[index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill) begin
            line_tag[index]  <= tag;
            line_data[index] <= fill_line;
        end else if (main_hit && write) begin
            line_data[index] <= store_merge(line_data[index], addr, size, wdata);
        end
    end

endmodule

`default_nettype wire

/* verilog/victim_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module victim_cache
    import dcache_pkg::*;
#(
    parameter int N_VICTIM = 4
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   lookup,
    input  logic   write,
    input  addr_t  addr,
    input  size_t  size,
    input  word_t  wdata,
    output logic   victim_hit,
    output block_t victim_block,
    input  logic   evict_valid,
    input  logic   evict_dirty,
    input  addr_t  evict_addr,
    input  block_t evict_block,
    output logic   wb_valid,
    output addr_t  wb_addr,
    output block_t wb_block
);

    localparam int IDX_BITS = (N_VICTIM > 1) ? $clog2(N_VICTIM) : 1;
    localparam int LINE_BITS = 32 - BLOCK_OFFSET_BITS;

    typedef logic [IDX_BITS-1:0] idx_t;
    typedef logic [LINE_BITS-1:0] line_addr_t;

    logic [N_VICTIM-1:0] entry_valid;
    logic [N_VICTIM-1:0] entry_dirty;
    idx_t                entry_age [N_VICTIM];   // 0 is most recently used
    line_addr_t          entry_line [N_VICTIM];
    block_t              entry_data [N_VICTIM];

    logic hit_found;
    idx_t hit_idx;
    logic free_found;
    idx_t free_idx;
    idx_t oldest_idx;
    idx_t oldest_age;
    idx_t fill_idx;

    always_comb begin
        hit_found = 1'b0;
        hit_idx = '0;
        free_found = 1'b0;
        free_idx = '0;
        oldest_idx = '0;
        oldest_age = '0;
        for (int i = 0; i < N_VICTIM; i++) begin
            if (entry_valid[i] && !hit_found &&
                entry_line[i] == addr[31:BLOCK_OFFSET_BITS]) begin
                hit_found = 1'b1;
                hit_idx = idx_t'(i);
            end
            if (!entry_valid[i] && !free_found) begin
                free_found = 1'b1;
                free_idx = idx_t'(i);
            end
            if (entry_valid[i] && entry_age[i] >= oldest_age) begin
                oldest_age = entry_age[i];
                oldest_idx = idx_t'(i);
            end
        end
    end

    assign victim_hit = lookup && hit_found;
    assign victim_block = entry_data[hit_idx];

    assign fill_idx = free_found ? free_idx : oldest_idx;

    // a full cache sends its dirty LRU entry to memory
    assign wb_valid = evict_valid && !free_found && entry_dirty[oldest_idx];
    assign wb_addr = {entry_line[oldest_idx], {BLOCK_OFFSET_BITS{1'b0}}};
    assign wb_block = entry_data[oldest_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
            entry_dirty <= '0;
            for (int i = 0; i < N_VICTIM; i++) begin
                entry_age[i] <= '0;
            end
        end else if (evict_valid) begin
            for (int i = 0; i < N_VICTIM; i++) begin
                if (entry_valid[i]) begin
                    entry_age[i] <= entry_age[i] + 1'b1;
                end
            end
            entry_valid[fill_idx] <= 1'b1;
            entry_dirty[fill_idx] <= evict_dirty;
            entry_age[fill_idx] <= '0;          // newcomer is youngest
        end else if (victim_hit) begin
            // only entries younger than the hit one move back
            for (int i = 0; i < N_VICTIM; i++) begin
                if (entry_valid[i] && entry_age[i] < entry_age[hit_idx]) begin
                    entry_age[i] <= entry_age[i] + 1'b1;
                end
            end
            entry_age[hit_idx] <= '0;
            if (write) begin
                entry_dirty[hit_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (evict_valid) begin
            entry_line[fill_idx] <= evict_addr[31:BLOCK_OFFSET_BITS];
            entry_data[fill_idx] <= evict_block;
        end else if (victim_hit && write) begin
            entry_data[hit_idx] <= store_merge(entry_data[hit_idx], addr, size, wdata);
        end
    end

endmodule

`default_nettype wire

/* verilog/miss_control.sv */
`timescale 1ns/1ps
`default_nettype none

module miss_control
    import dcache_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   req_valid,
    input  logic   req_write,
    input  addr_t  req_addr,
    input  size_t  req_size,
    input  word_t  req_wdata,
    output logic   req_ready,
    output logic   resp_valid,
    output word_t  resp_data,
    output logic   lookup,
    output addr_t  hold_addr,
    output logic   hold_write,
    output size_t  hold_size,
    output word_t  hold_wdata,
    input  logic   main_hit,
    input  logic   victim_hit,
    input  block_t main_block,
    input  block_t victim_block,
    output logic   fill,
    output block_t fill_block,
    input  logic   wb_valid,
    input  addr_t  wb_addr,
    input  block_t wb_block,
    output logic   mem_req_valid,
    output logic   mem_req_write,
    output addr_t  mem_req_addr,
    output block_t mem_req_wdata,
    input  logic   mem_req_ready,
    input  logic   mem_resp_valid,
    input  block_t mem_resp_data
);

    ctrl_state_e state;
    logic        any_hit;
    logic        start_refill;
    logic        start_wb;
    block_t      src_block;

    // zero-extended load value from its place in the line
    function automatic word_t load_word(block_t line, addr_t addr, size_t size);
        block_t shifted;
        shifted = line >> (addr[BLOCK_OFFSET_BITS-1:0] * 8);
        case (size)
            size_byte: return word_t'(shifted[7:0]);
            size_half: return word_t'(shifted[15:0]);
            default:   return shifted[31:0];
        endcase
    endfunction

    assign req_ready = (state == idle) && !lookup;
    assign any_hit = main_hit || victim_hit;

    assign fill = (state == refill) && mem_resp_valid;
    assign fill_block = mem_resp_data;

    assign start_refill = (state == idle) && lookup && !any_hit;
    assign start_wb = fill && wb_valid;
    assign src_block = fill ? mem_resp_data : (main_hit ? main_block : victim_block);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= idle;
            lookup <= 1'b0;
            resp_valid <= 1'b0;
            mem_req_valid <= 1'b0;
        end else begin
            lookup <= req_valid && req_ready;
            resp_valid <= 1'b0;
            case (state)
                idle: begin
                    if (lookup && any_hit) begin
                        resp_valid <= 1'b1;
                    end else if (start_refill) begin
                        mem_req_valid <= 1'b1;
                        state <= refill;
                    end
                end
                refill: begin
                    if (mem_req_valid && mem_req_ready) begin
                        mem_req_valid <= 1'b0;
                    end
                    if (start_wb) begin
                        mem_req_valid <= 1'b1;      // dirty victim pushed out by the fill
                        state <= writeback;
                    end else if (fill) begin
                        resp_valid <= 1'b1;
                        state <= respond;
                    end
                end
                writeback: begin
                    if (mem_req_ready) begin        // write done at handshake
                        mem_req_valid <= 1'b0;
                        resp_valid <= 1'b1;
                        state <= respond;
                    end
                end
                default: state <= idle;             // respond returns to idle and ready comes back
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (req_valid && req_ready) begin
            hold_addr <= req_addr;
            hold_write <= req_write;
            hold_size <= req_size;
            hold_wdata <= req_wdata;
        end
        if (start_refill) begin
            mem_req_write <= 1'b0;
            mem_req_addr <= {hold_addr[31:BLOCK_OFFSET_BITS], {BLOCK_OFFSET_BITS{1'b0}}};
        end else if (start_wb) begin
            mem_req_write <= 1'b1;
            mem_req_addr <= wb_addr;
            mem_req_wdata <= wb_block;
        end
        if ((state == idle && lookup) || fill) begin
            resp_data <= hold_write ? '0 : load_word(src_block, hold_addr, hold_size);
        end
    end

endmodule

`default_nettype wire

/* verilog/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import dcache_pkg::*;
#(
    parameter int N_LINES  = 16,
    parameter int N_VICTIM = 4
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   req_valid,
    input  logic   req_write,
    input  addr_t  req_addr,
    input  size_t  req_size,
    input  word_t  req_wdata,
    output logic   req_ready,
    output logic   resp_valid,
    output word_t  resp_data,
    output logic   mem_req_valid,
    output logic   mem_req_write,
    output addr_t  mem_req_addr,
    output block_t mem_req_wdata,
    input  logic   mem_req_ready,
    input  logic   mem_resp_valid,
    input  block_t mem_resp_data
);

    logic   lookup;
    addr_t  hold_addr;
    logic   hold_write;
    size_t  hold_size;
    word_t  hold_wdata;
    logic   main_hit;
    block_t main_block;
    logic   victim_hit;
    block_t victim_block;
    logic   fill;
    block_t fill_block;
    logic   evict_valid;
    logic   evict_dirty;
    addr_t  evict_addr;
    block_t evict_block;
    logic   wb_valid;
    addr_t  wb_addr;
    block_t wb_block;

    miss_control miss_control_i (.*);

    main_cache #(
        .N_LINES (N_LINES)
    ) main_cache_i (
        .clock       (clock),
        .reset       (reset),
        .lookup      (lookup),
        .write       (hold_write),
        .fill        (fill),
        .addr        (hold_addr),
        .size        (hold_size),
        .wdata       (hold_wdata),
        .fill_block  (fill_block),
        .main_hit    (main_hit),
        .main_block  (main_block),
        .evict_valid (evict_valid),
        .evict_dirty (evict_dirty),
        .evict_addr  (evict_addr),
        .evict_block (evict_block)
    );

    victim_cache #(
        .N_VICTIM (N_VICTIM)
    ) victim_cache_i (
        .clock        (clock),
        .reset        (reset),
        .lookup       (lookup),
        .write        (hold_write),
        .addr         (hold_addr),
        .size         (hold_size),
        .wdata        (hold_wdata),
        .victim_hit   (victim_hit),
        .victim_block (victim_block),
        .evict_valid  (evict_valid),
        .evict_dirty  (evict_dirty),
        .evict_addr   (evict_addr),
        .evict_block  (evict_block),
        .wb_valid     (wb_valid),
        .wb_addr      (wb_addr),
        .wb_block     (wb_block)
    );

endmodule

`default_nettype wire

/* tests/mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_model
    import dcache_pkg::*;
#(
    parameter addr_t BASE  = 32'h2400_0000,
    parameter int    DEPTH = 4096
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   mem_req_valid,
    input  logic   mem_req_write,
    input  addr_t  mem_req_addr,
    input  block_t mem_req_wdata,
    output logic   mem_req_ready,
    output logic   mem_resp_valid,
    output block_t mem_resp_data
);

    logic [7:0] image [DEPTH];   // byte image of the window starting at BASE
    logic       pending;
    logic       answer_now;
    int         wait_cycles;
    addr_t      read_addr;

    function automatic logic [7:0] pattern_byte(addr_t a);
        return a[7:0] ^ {a[11:8], a[15:12]} ^ a[23:16] ^ a[31:24] ^ 8'h3c;
    endfunction

    function automatic block_t read_line(addr_t a);
        block_t line;
        for (int k = 0; k < 8; k++) begin
            line[8*k +: 8] = image[a - BASE + k];   // little endian within the line
        end
        return line;
    endfunction

    initial begin
        mem_req_ready = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data = '0;
        pending = 1'b0;
        wait_cycles = 0;
        read_addr = '0;
        for (int i = 0; i < DEPTH; i++) begin
            image[i] = pattern_byte(BASE + i);
        end
    end

    always @(posedge clock) begin
        if (reset) begin
            pending = 1'b0;
            mem_req_ready <= #1 1'b0;
            mem_resp_valid <= #1 1'b0;
        end else begin
            answer_now = pending && (wait_cycles == 0);
            mem_resp_valid <= #1 answer_now;
            if (answer_now) begin
                mem_resp_data <= #1 read_line(read_addr);
                pending = 1'b0;
            end else if (pending) begin
                wait_cycles--;
            end
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req_write) begin
                    for (int k = 0; k < 8; k++) begin
                        image[mem_req_addr - BASE + k] = mem_req_wdata[8*k +: 8];
                    end
                end else begin
                    pending = 1'b1;
                    read_addr = mem_req_addr;
                    wait_cycles = $urandom_range(3, 0);   // extra cycles before the answer
                end
            end
            mem_req_ready <= #1 1'($urandom_range(1, 0));
        end
    end

endmodule

`default_nettype wire

/* tests/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
();

    localparam int    N_LINES  = 16;
    localparam int    N_VICTIM = 4;
    localparam addr_t BASE     = 32'h2400_0000;
    localparam int    DEPTH    = 4096;
    localparam int    STRIDE   = N_LINES * 8;   // same index with the next tag
    localparam int    TIMEOUT  = 200;

    logic   clock;
    logic   reset;
    logic   req_valid;
    logic   req_write;
    addr_t  req_addr;
    size_t  req_size;
    word_t  req_wdata;
    logic   req_ready;
    logic   resp_valid;
    word_t  resp_data;
    logic   mem_req_valid;
    logic   mem_req_write;
    addr_t  mem_req_addr;
    block_t mem_req_wdata;
    logic   mem_req_ready;
    logic   mem_resp_valid;
    block_t mem_resp_data;

    logic [7:0] ref_mem [DEPTH];   // what memory would hold with no cache in between
    word_t      expect_data;
    logic       check_hit;
    int         wb_count;

    dcache_top #(
        .N_LINES  (N_LINES),
        .N_VICTIM (N_VICTIM)
    ) dcache_top_i (.*);

    mem_model #(
        .BASE  (BASE),
        .DEPTH (DEPTH)
    ) mem_model_i (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [7:0] initial_byte(addr_t a);
        return a[7:0] ^ {a[11:8], a[15:12]} ^ a[23:16] ^ a[31:24] ^ 8'h3c;
    endfunction

    function automatic block_t ref_line(addr_t a);
        block_t line;
        for (int k = 0; k < 8; k++) begin
            line[8*k +: 8] = ref_mem[a - BASE + k];
        end
        return line;
    endfunction

    task automatic print_failure(input string line);
        $display("%s", line);
        $display("Test failed");
    endtask

    // one request and its response with an optional hit timing check
    task automatic access(input logic write, input addr_t addr, input size_t size,
                          input word_t wdata, input logic hit);
        int nbytes;
        int waited;
        nbytes = 1 << size;
        #1;
        expect_data = '0;   // stores answer with zero
        for (int k = 0; k < nbytes; k++) begin
            if (write) begin
                ref_mem[addr - BASE + k] = wdata[8*k +: 8];
            end else begin
                expect_data[8*k +: 8] = ref_mem[addr - BASE + k];
            end
        end
        check_hit = hit;
        req_valid = 1'b1;
        req_write = write;
        req_addr = addr;
        req_size = size;
        req_wdata = wdata;
        waited = 0;
        do begin
            @(posedge clock);
            waited++;
            if (waited > TIMEOUT) begin
                print_failure($sformatf("timeout waiting for req_ready, addr %h", addr));
                $fatal(1);
            end
        end while (!req_ready);
        #1 req_valid = 1'b0;
        waited = 0;
        do begin
            @(posedge clock);
            waited++;
            if (waited > TIMEOUT) begin
                print_failure($sformatf("timeout waiting for resp_valid, addr %h", addr));
                $fatal(1);
            end
        end while (!resp_valid);
    endtask

    always @(posedge clock) begin
        if (mem_req_valid && mem_req_ready && mem_req_write) begin
            wb_count <= wb_count + 1;
        end
    end

    assert property (@(posedge clock) $fell(reset) |-> req_ready && !resp_valid && !mem_req_valid)
    else begin
        print_failure($sformatf("Mismatch at %0t: outputs not idle after reset", $time));
        $fatal(1);
    end

    assert property (@(posedge clock) disable iff (reset)
        req_valid && req_ready && check_hit |->
        ##1 !mem_req_valid ##1 (resp_valid && !mem_req_valid))
    else begin
        print_failure($sformatf("Mismatch at %0t: hit not answered in one cycle", $time));
        $fatal(1);
    end

    assert property (@(posedge clock) disable iff (reset) resp_valid |-> resp_data == expect_data)
    else begin
        print_failure($sformatf("Mismatch at %0t: resp_data %h, expected %h",
                                $time, resp_data, expect_data));
        $fatal(1);
    end

    assert property (@(posedge clock) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_write) &&
        $stable(mem_req_addr) && $stable(mem_req_wdata))
    else begin
        print_failure($sformatf("Mismatch at %0t: memory request changed before ready", $time));
        $fatal(1);
    end

    assert property (@(posedge clock) disable iff (reset)
        mem_req_valid && mem_req_ready && mem_req_write |->
        mem_req_wdata == ref_line(mem_req_addr))
    else begin
        print_failure($sformatf("Mismatch at %0t: write-back of %h carries %h",
                                $time, mem_req_addr, mem_req_wdata));
        $fatal(1);
    end

    initial begin
        addr_t addr;
        size_t size;
        void'($urandom(76));
        reset = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_size = size_word;
        req_wdata = '0;
        check_hit = 1'b0;
        expect_data = '0;
        wb_count = 0;
        for (int i = 0; i < DEPTH; i++) begin
            ref_mem[i] = initial_byte(BASE + i);
        end
        repeat (3) @(posedge clock);
        #1 reset = 1'b0;
        @(posedge clock);

        access(1'b0, BASE + 32'h08, size_word, '0, 1'b0);   // cold miss
        access(1'b0, BASE + 32'h0c, size_word, '0, 1'b1);
        access(1'b0, BASE + 32'h09, size_byte, '0, 1'b1);
        access(1'b1, BASE + 32'h0a, size_byte, 32'h0000_00a7, 1'b1);
        access(1'b1, BASE + 32'h0c, size_half, 32'h0000_b3c4, 1'b1);
        access(1'b1, BASE + 32'h08, size_byte, 32'hffff_ff11, 1'b1);
        access(1'b0, BASE + 32'h08, size_word, '0, 1'b1);
        access(1'b0, BASE + 32'h0c, size_word, '0, 1'b1);
        access(1'b0, BASE + 32'h0a, size_half, '0, 1'b1);
        access(1'b1, BASE + 32'h44, size_word, 32'hdead_beef, 1'b0);   // store miss allocates
        access(1'b0, BASE + 32'h46, size_half, '0, 1'b1);
        access(1'b0, BASE + 32'h40, size_word, '0, 1'b1);

        // conflict on index 1 pushes the dirty line into the victim cache
        access(1'b0, BASE + 32'h08 + STRIDE, size_word, '0, 1'b0);
        access(1'b0, BASE + 32'h08, size_word, '0, 1'b1);
        access(1'b1, BASE + 32'h0e, size_half, 32'h0000_5a5a, 1'b1);

        // dirty lines on index 3 overflow the victim entries
        for (int i = 0; i < N_VICTIM + 3; i++) begin
            access(1'b1, BASE + 32'h18 + i * STRIDE, size_word, 32'h1000_0000 + i, 1'b0);
        end
        for (int i = 0; i < N_VICTIM + 3; i++) begin
            access(1'b0, BASE + 32'h18 + i * STRIDE, size_word, '0, 1'b0);
        end
        access(1'b0, BASE + 32'h0c, size_word, '0, 1'b0);

        for (int n = 0; n < 80; n++) begin
            size = size_t'($urandom_range(2, 0));
            addr = BASE + addr_t'($urandom_range(DEPTH - 1, 0) & ~((1 << size) - 1));
            access(1'($urandom_range(1, 0)), addr, size, $urandom, 1'b0);
        end

        if (wb_count > 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            print_failure("no dirty line was ever written back to memory");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* compile.f */
verilog/dcache_pkg.sv
verilog/main_cache.sv
verilog/victim_cache.sv
verilog/miss_control.sv
verilog/dcache_top.sv
tests/mem_model.sv
tests/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - verilog/dcache_pkg.sv
  - verilog/main_cache.sv
  - verilog/victim_cache.sv
  - verilog/miss_control.sv
  - verilog/dcache_top.sv
  - target: test
    files:
      - tests/mem_model.sv
      - tests/dcache_tb.sv
